//--- lsu_exec.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_stage_reg.sv
hdl/store_lane_align.sv
hdl/load_lane_merge.sv
hdl/bus_read_fsm.sv
hdl/bus_write_fsm.sv
hdl/lsu_exec.sv
test/lsu_exec_tb.sv

//--- run.sh
#!/usr/bin/env bash
verilator --binary --timing --timescale 1ns/100ps -f lsu_exec.f --top-module lsu_exec_tb \
	-o sim_lsu_exec > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_lsu_exec > sim.log 2>&1 || echo "simulator returned a failing status"
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }

//--- test/lsu_exec_tb.sv
module lsu_exec_tb import lsu_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_INSTR   = 400;
	localparam int CYCLE_LIMIT = NUM_INSTR * 40;

	logic       clock;
	logic       reset;
	logic       in_valid;
	logic       is_store;
	mem_funct_u funct;
	word_t      base;
	word_t      offset;
	word_t      store_data;
	reg_addr_t  rd;
	logic       allowin;
	logic       ar_valid;
	logic       ar_ready;
	word_t      ar_addr;
	logic       r_valid;
	logic       r_ready;
	bus_word_t  r_data;
	logic       aw_valid;
	logic       aw_ready;
	word_t      aw_addr;
	logic       w_valid;
	logic       w_ready;
	bus_word_t  w_data;
	strb_t      w_strb;
	logic       b_valid;
	logic       b_ready;
	logic       reg_wen;
	reg_addr_t  reg_waddr;
	word_t      reg_wdata;
	logic       done_store;

	// memory behind the bus and the reference copy
	logic [7:0] bus_mem [0:255];
	logic [7:0] model_mem [0:255];

	integer    seed;
	int        cycle_count;
	int        issued;
	int        accepted;
	logic      offer;
	mem_size_e gen_size;
	logic      gen_uns;

	// access held in the stage
	logic      busy;
	logic      cur_store;
	mem_size_e cur_size;
	logic      cur_uns;
	word_t     cur_eff;
	word_t     cur_data;
	reg_addr_t cur_rd;
	int        rd_beats;
	int        wr_beats;

	// bus responder
	logic  rd_pending;
	word_t rd_addr;
	logic  wr_resp_pending;
	word_t wr_addr;

	// requests left open in the previous cycle
	logic      prev_ar_open;
	word_t     prev_ar_addr;
	logic      prev_aw_open;
	word_t     prev_aw_addr;
	logic      prev_w_open;
	bus_word_t prev_w_data;
	strb_t     prev_w_strb;

	lsu_exec dut0 (
		.clock      (clock),
		.reset      (reset),
		.in_valid   (in_valid),
		.is_store   (is_store),
		.funct      (funct),
		.base       (base),
		.offset     (offset),
		.store_data (store_data),
		.rd         (rd),
		.allowin    (allowin),
		.ar_valid   (ar_valid),
		.ar_ready   (ar_ready),
		.ar_addr    (ar_addr),
		.r_valid    (r_valid),
		.r_ready    (r_ready),
		.r_data     (r_data),
		.aw_valid   (aw_valid),
		.aw_ready   (aw_ready),
		.aw_addr    (aw_addr),
		.w_valid    (w_valid),
		.w_ready    (w_ready),
		.w_data     (w_data),
		.w_strb     (w_strb),
		.b_valid    (b_valid),
		.b_ready    (b_ready),
		.reg_wen    (reg_wen),
		.reg_waddr  (reg_waddr),
		.reg_wdata  (reg_wdata),
		.done_store (done_store)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, an access never completed", CYCLE_LIMIT);
			stop_run();
		end
	end

	task automatic stop_run();
		$display("tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("[ERROR] %s, access %0d: expected %h actual %h", name, accepted,
				expected, actual);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("[ERROR] %s, access %0d: expected %h actual %h", name, accepted,
				expected, actual);
			stop_run();
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t expected,
		input reg_addr_t actual);
		if (expected !== actual) begin
			$display("[ERROR] %s, access %0d: expected %0d actual %0d", name, accepted,
				expected, actual);
			stop_run();
		end
	endtask

	task automatic check_strb(input string name, input strb_t expected, input strb_t actual);
		if (expected !== actual) begin
			$display("[ERROR] %s, access %0d: expected %b actual %b", name, accepted,
				expected, actual);
			stop_run();
		end
	endtask

	task automatic check_bus(input string name, input bus_word_t expected,
		input bus_word_t actual);
		if (expected !== actual) begin
			$display("[ERROR] %s, access %0d: expected %h actual %h", name, accepted,
				expected, actual);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("[ERROR] %s, access %0d: expected %b actual %b", name, accepted,
				expected, actual);
			stop_run();
		end
	endtask

	task automatic report(input string what);
		$display("access %0d: %s", accepted, what);
		stop_run();
	endtask

	function automatic int unsigned rand_range(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic rand_bit();
		return rand_range(2) == 1;
	endfunction

	// memory wraps every 256 bytes
	function automatic logic [7:0] byte_addr(input word_t addr, input int k);
		return 8'(addr + word_t'(k));
	endfunction

	function automatic int size_bytes(input mem_size_e size);
		case (size)
			MEM_BYTE: return 1;
			MEM_HALF: return 2;
			default:  return 4;
		endcase
	endfunction

	// two beats when the last byte lies past lane 7
	function automatic int beats_needed();
		return (int'(cur_eff[2:0]) + size_bytes(cur_size) - 1 > 7) ? 2 : 1;
	endfunction

	function automatic word_t beat_addr(input int beat);
		return {cur_eff[31:3], 3'b000} + word_t'(8 * beat);
	endfunction

	function automatic strb_t expect_strb(input int beat);
		strb_t s;
		int    pos;
		s = '0;
		for (int k = 0; k < size_bytes(cur_size); k++) begin
			pos = int'(cur_eff[2:0]) + k;
			if (beat == 0 && pos < 8)
				s[3'(pos)] = 1'b1;
			else if (beat == 1 && pos >= 8)
				s[3'(pos - 8)] = 1'b1;
		end
		return s;
	endfunction

	// little endian bytes at the effective address, then extension
	function automatic word_t model_load();
		word_t v;
		v = '0;
		for (int k = 0; k < size_bytes(cur_size); k++) begin
			v[8*k +: 8] = model_mem[byte_addr(cur_eff, k)];
		end
		if (!cur_uns) begin
			if (cur_size == MEM_BYTE && v[7])
				v[31:8] = '1;
			else if (cur_size == MEM_HALF && v[15])
				v[31:16] = '1;
		end
		return v;
	endfunction

	task automatic model_store();
		for (int k = 0; k < size_bytes(cur_size); k++) begin
			model_mem[byte_addr(cur_eff, k)] = cur_data[8*k +: 8];
		end
	endtask

	task automatic new_instruction();
		mem_funct_u f;
		f = '0;
		is_store = rand_bit();
		gen_size = mem_size_e'(2'(rand_range(3)));
		gen_uns = !is_store && gen_size != MEM_WORD && rand_bit();
		if (is_store) begin
			f.st.size = gen_size;
		end else begin
			f.ld.is_unsigned = gen_uns;
			f.ld.size = gen_size;
		end
		funct = f;
		base = word_t'($random(seed));
		// signed 12-bit immediate range
		offset = word_t'(rand_range(4096)) - 32'd2048;
		store_data = word_t'($random(seed));
		rd = reg_addr_t'(rand_range(32));
		offer = 1'b1;
		issued++;
	endtask

	task automatic drive_inputs();
		ar_ready = rand_bit();
		aw_ready = rand_bit();
		w_ready = rand_bit();
		// a raised valid stays up until its handshake
		if (!rd_pending)
			r_valid = 1'b0;
		else if (!r_valid)
			r_valid = rand_bit();
		if (r_valid) begin
			for (int i = 0; i < 8; i++) begin
				r_data[8*i +: 8] = bus_mem[byte_addr(rd_addr, i)];
			end
		end else begin
			r_data = {$random(seed), $random(seed)};
		end
		if (!wr_resp_pending)
			b_valid = 1'b0;
		else if (!b_valid)
			b_valid = rand_bit();
		if (!offer && issued < NUM_INSTR && rand_range(4) != 0)
			new_instruction();
		in_valid = offer;
	endtask

	task automatic check_held_requests();
		if (prev_ar_open) begin
			check_flag("ar_valid held", 1'b1, ar_valid);
			check_addr("ar_addr held", prev_ar_addr, ar_addr);
		end
		if (prev_aw_open) begin
			check_flag("aw_valid held", 1'b1, aw_valid);
			check_addr("aw_addr held", prev_aw_addr, aw_addr);
		end
		if (prev_w_open) begin
			check_flag("w_valid held", 1'b1, w_valid);
			check_bus("w_data held", prev_w_data, w_data);
			check_strb("w_strb held", prev_w_strb, w_strb);
		end
		prev_ar_open = ar_valid && !ar_ready;
		prev_ar_addr = ar_addr;
		prev_aw_open = aw_valid && !aw_ready;
		prev_aw_addr = aw_addr;
		prev_w_open = w_valid && !w_ready;
		prev_w_data = w_data;
		prev_w_strb = w_strb;
	endtask

	task automatic handle_read();
		if (ar_valid && ar_ready) begin
			if (!busy || cur_store || rd_beats >= beats_needed())
				report("read request with no load beat left to issue");
			check_addr("ar_addr", beat_addr(rd_beats), ar_addr);
			rd_addr = ar_addr;
			rd_pending = 1'b1;
			rd_beats++;
		end
		if (r_valid && r_ready)
			rd_pending = 1'b0;
	endtask

	task automatic handle_write();
		if (aw_valid && aw_ready) begin
			if (!busy || !cur_store || wr_beats >= beats_needed())
				report("write request with no store beat left to issue");
			check_addr("aw_addr", beat_addr(wr_beats), aw_addr);
			wr_addr = aw_addr;
		end
		if (w_valid && w_ready) begin
			if (!busy || !cur_store || wr_beats >= beats_needed())
				report("write data with no store beat left to issue");
			check_strb("w_strb", expect_strb(wr_beats), w_strb);
			for (int i = 0; i < 8; i++) begin
				if (w_strb[i])
					bus_mem[byte_addr(wr_addr, i)] = w_data[8*i +: 8];
			end
			wr_beats++;
			wr_resp_pending = 1'b1;
		end
		if (b_valid && b_ready)
			wr_resp_pending = 1'b0;
	endtask

	task automatic handle_completion();
		if (reg_wen) begin
			check_reg("reg_waddr", cur_rd, reg_waddr);
			check_word("reg_wdata", model_load(), reg_wdata);
			busy = 1'b0;
		end
		if (done_store) begin
			model_store();
			busy = 1'b0;
		end
	endtask

	// everything seen here holds until the next rising edge
	task automatic sample_cycle();
		logic finishing;
		check_held_requests();
		// response handshake of the last beat of the access in the stage
		finishing = 1'b0;
		if (busy && cur_store)
			finishing = b_valid && b_ready && wr_beats == beats_needed();
		else if (busy)
			finishing = r_valid && r_ready && rd_beats == beats_needed();
		check_flag("reg_wen", finishing && !cur_store, reg_wen);
		check_flag("done_store", finishing && cur_store, done_store);
		check_flag("allowin", !busy || finishing, allowin);
		handle_read();
		handle_write();
		handle_completion();
		if (in_valid && allowin) begin
			busy = 1'b1;
			cur_store = is_store;
			cur_size = gen_size;
			cur_uns = gen_uns;
			cur_eff = base + offset;
			cur_data = store_data;
			cur_rd = rd;
			rd_beats = 0;
			wr_beats = 0;
			offer = 1'b0;
			accepted++;
		end
	endtask

	task automatic check_idle_after_reset();
		check_flag("allowin after reset", 1'b1, allowin);
		check_flag("ar_valid after reset", 1'b0, ar_valid);
		check_flag("r_ready after reset", 1'b0, r_ready);
		check_flag("aw_valid after reset", 1'b0, aw_valid);
		check_flag("w_valid after reset", 1'b0, w_valid);
		check_flag("b_ready after reset", 1'b0, b_ready);
		check_flag("reg_wen after reset", 1'b0, reg_wen);
		check_flag("done_store after reset", 1'b0, done_store);
	endtask

	initial begin
		seed = 32'h2820;
		clock = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		is_store = 1'b0;
		funct = '0;
		base = '0;
		offset = '0;
		store_data = '0;
		rd = '0;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = '0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		cycle_count = 0;
		issued = 0;
		accepted = 0;
		offer = 1'b0;
		gen_size = MEM_BYTE;
		gen_uns = 1'b0;
		busy = 1'b0;
		cur_store = 1'b0;
		cur_size = MEM_BYTE;
		cur_uns = 1'b0;
		cur_eff = '0;
		cur_data = '0;
		cur_rd = '0;
		rd_beats = 0;
		wr_beats = 0;
		rd_pending = 1'b0;
		rd_addr = '0;
		wr_resp_pending = 1'b0;
		wr_addr = '0;
		prev_ar_open = 1'b0;
		prev_ar_addr = '0;
		prev_aw_open = 1'b0;
		prev_aw_addr = '0;
		prev_w_open = 1'b0;
		prev_w_data = '0;
		prev_w_strb = '0;
		// odd multiplier touches every address bit
		for (int i = 0; i < 256; i++) begin
			bus_mem[8'(i)] = 8'(i * 29 + 7);
			model_mem[8'(i)] = 8'(i * 29 + 7);
		end
		repeat (4) @(negedge clock);
		reset = 1'b0;
		#1;
		check_idle_after_reset();
		while (!(issued == NUM_INSTR && !offer && !busy)) begin
			@(negedge clock);
			drive_inputs();
			#1;
			sample_cycle();
		end
		for (int i = 0; i < 256; i++) begin
			check_word($sformatf("memory byte %0d", i), word_t'(model_mem[8'(i)]),
				word_t'(bus_mem[8'(i)]));
		end
		$display("all tests passed");
		$finish;
	end

endmodule

//--- hdl/lsu_exec.sv
`include "lsu_defs.svh"

module lsu_exec import lsu_pkg::*; (
	input  logic       clock,
	input  logic       reset,

	// previous stage
	input  logic       in_valid,
	input  logic       is_store,
	input  mem_funct_u funct,
	input  word_t      base,
	input  word_t      offset,
	input  word_t      store_data,
	input  reg_addr_t  rd,
	output logic       allowin,

	// read address and data
	output logic       ar_valid,
	input  logic       ar_ready,
	output word_t      ar_addr,
	input  logic       r_valid,
	output logic       r_ready,
	input  bus_word_t  r_data,

	// write address, data and response
	output logic       aw_valid,
	input  logic       aw_ready,
	output word_t      aw_addr,
	output logic       w_valid,
	input  logic       w_ready,
	output bus_word_t  w_data,
	output strb_t      w_strb,
	input  logic       b_valid,
	output logic       b_ready,

	// register file write and store completion
	output logic       reg_wen,
	output reg_addr_t  reg_waddr,
	output word_t      reg_wdata,
	output logic       done_store
);

	logic                      load_go;
	logic                      store_go;
	logic                      split;
	mem_funct_u                st_funct;
	word_t                     eff_addr;
	word_t                     st_data;
	logic [`LSU_LANE_BITS-1:0] lane;
	logic                      access_done;
	logic                      first_beat_take;
	logic                      second_beat;

	assign lane = eff_addr[`LSU_LANE_BITS-1:0];
	assign access_done = reg_wen || done_store;

	lsu_stage_reg u_stage (
		.clock       (clock),
		.reset       (reset),
		.in_valid    (in_valid),
		.is_store    (is_store),
		.funct       (funct),
		.base        (base),
		.offset      (offset),
		.store_data  (store_data),
		.rd          (rd),
		.access_done (access_done),
		.allowin     (allowin),
		.stage_valid (),
		.load_go     (load_go),
		.store_go    (store_go),
		.split       (split),
		.st_is_store (),
		.st_funct    (st_funct),
		.eff_addr    (eff_addr),
		.st_data     (st_data),
		.st_rd       (reg_waddr)
	);

	bus_read_fsm u_read (
		.clock           (clock),
		.reset           (reset),
		.load_go         (load_go),
		.split           (split),
		.eff_addr        (eff_addr),
		.ar_ready        (ar_ready),
		.r_valid         (r_valid),
		.ar_valid        (ar_valid),
		.r_ready         (r_ready),
		.ar_addr         (ar_addr),
		.first_beat_take (first_beat_take),
		.load_done       (reg_wen)
	);

	load_lane_merge u_merge (
		.clock           (clock),
		.reset           (reset),
		.first_beat_take (first_beat_take),
		.r_data          (r_data),
		.funct           (st_funct),
		.lane            (lane),
		.split           (split),
		.load_value      (reg_wdata)
	);

	bus_write_fsm u_write (
		.clock       (clock),
		.reset       (reset),
		.store_go    (store_go),
		.split       (split),
		.eff_addr    (eff_addr),
		.aw_ready    (aw_ready),
		.w_ready     (w_ready),
		.b_valid     (b_valid),
		.aw_valid    (aw_valid),
		.w_valid     (w_valid),
		.b_ready     (b_ready),
		.aw_addr     (aw_addr),
		.second_beat (second_beat),
		.store_done  (done_store)
	);

	store_lane_align u_align (
		.funct       (st_funct),
		.lane        (lane),
		.data        (st_data),
		.second_beat (second_beat),
		.w_data      (w_data),
		.w_strb      (w_strb)
	);

endmodule

//--- hdl/bus_write_fsm.sv
`include "lsu_defs.svh"

module bus_write_fsm import lsu_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  store_go,
	input  logic  split,
	input  word_t eff_addr,
	input  logic  aw_ready,
	input  logic  w_ready,
	input  logic  b_valid,
	output logic  aw_valid,
	output logic  w_valid,
	output logic  b_ready,
	output word_t aw_addr,
	output logic  second_beat,
	output logic  store_done
);

	localparam logic [2:0] WR_IDLE = 3'd0;
	localparam logic [2:0] WR_ADDR = 3'd1;
	localparam logic [2:0] WR_DATA = 3'd2;
	localparam logic [2:0] WR_RESP = 3'd3;
	localparam logic [2:0] WR_GAP  = 3'd4;

	localparam word_t BEAT_BYTES = `LSU_STRB_WIDTH;

	logic [2:0] state;
	logic [2:0] next_state;
	logic       aw_hs;
	logic       w_hs;
	logic       b_hs;
	logic       last_beat;
	word_t      low_addr;

	assign aw_hs = aw_valid && aw_ready;
	assign w_hs  = w_valid && w_ready;
	assign b_hs  = b_valid && b_ready;

	assign last_beat = second_beat || !split;

	always_comb begin
		next_state = state;
		case (state)
			WR_IDLE:
				if (store_go)
					next_state = WR_ADDR;
			WR_ADDR:
				if (aw_hs)
					next_state = WR_DATA;
			WR_DATA:
				if (w_hs)
					next_state = WR_RESP;
			WR_RESP:
				if (b_hs)
					next_state = last_beat ? WR_IDLE : WR_GAP;
			WR_GAP:
				next_state = WR_ADDR;
			default:
				next_state = WR_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= WR_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// set by the first response of a split store, cleared by the final one
	always_ff @(posedge clock) begin
		if (reset) begin
			second_beat <= 1'b0;
		end else if (state == WR_RESP && b_hs) begin
			second_beat <= !last_beat;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			aw_valid <= 1'b0;
		end else begin
			aw_valid <= state == WR_ADDR && !aw_hs;
		end
	end

	// data phase opens on the address handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			w_valid <= 1'b0;
		end else if (aw_hs) begin
			w_valid <= 1'b1;
		end else if (w_hs) begin
			w_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			b_ready <= 1'b0;
		end else if (w_hs) begin
			b_ready <= 1'b1;
		end else if (b_hs) begin
			b_ready <= 1'b0;
		end
	end

	assign low_addr = {eff_addr[`LSU_XLEN-1:`LSU_LANE_BITS], {`LSU_LANE_BITS{1'b0}}};
	assign aw_addr  = second_beat ? low_addr + BEAT_BYTES : low_addr;

	assign store_done = state == WR_RESP && b_hs && last_beat;

endmodule

//--- hdl/bus_read_fsm.sv
`include "lsu_defs.svh"

module bus_read_fsm import lsu_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  load_go,
	input  logic  split,
	input  word_t eff_addr,
	input  logic  ar_ready,
	input  logic  r_valid,
	output logic  ar_valid,
	output logic  r_ready,
	output word_t ar_addr,
	output logic  first_beat_take,
	output logic  load_done
);

	localparam logic [2:0] RD_IDLE  = 3'd0;
	localparam logic [2:0] RD_REQ   = 3'd1;
	localparam logic [2:0] RD_WAIT  = 3'd2;
	localparam logic [2:0] RD_GAP   = 3'd3;
	localparam logic [2:0] RD_REQ2  = 3'd4;
	localparam logic [2:0] RD_WAIT2 = 3'd5;

	localparam word_t BEAT_BYTES = `LSU_STRB_WIDTH;

	logic [2:0] state;
	logic [2:0] next_state;
	logic       ar_hs;
	logic       r_hs;
	logic       second;
	word_t      low_addr;

	assign ar_hs = ar_valid && ar_ready;
	assign r_hs  = r_valid && r_ready;

	always_comb begin
		next_state = state;
		case (state)
			RD_IDLE:
				if (load_go)
					next_state = RD_REQ;
			RD_REQ:
				if (ar_hs)
					next_state = RD_WAIT;
			RD_WAIT:
				if (r_hs)
					next_state = split ? RD_GAP : RD_IDLE;
			// one idle cycle before the upper bus word
			RD_GAP:
				next_state = RD_REQ2;
			RD_REQ2:
				if (ar_hs)
					next_state = RD_WAIT2;
			RD_WAIT2:
				if (r_hs)
					next_state = RD_IDLE;
			default:
				next_state = RD_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RD_IDLE;
		end else begin
			state <= next_state;
		end
	end

	// raised the cycle after entering a request state, dropped on handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			ar_valid <= 1'b0;
		end else begin
			ar_valid <= (state == RD_REQ || state == RD_REQ2) && !ar_hs;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			r_ready <= 1'b0;
		end else if (ar_hs) begin
			r_ready <= 1'b1;
		end else if (r_hs) begin
			r_ready <= 1'b0;
		end
	end

	assign second   = state == RD_GAP || state == RD_REQ2 || state == RD_WAIT2;
	assign low_addr = {eff_addr[`LSU_XLEN-1:`LSU_LANE_BITS], {`LSU_LANE_BITS{1'b0}}};
	assign ar_addr  = second ? low_addr + BEAT_BYTES : low_addr;

	assign first_beat_take = state == RD_WAIT && split && r_hs;
	assign load_done = r_hs && (state == RD_WAIT2 || (state == RD_WAIT && !split));

endmodule

//--- hdl/load_lane_merge.sv
`include "lsu_defs.svh"

module load_lane_merge import lsu_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      first_beat_take,
	input  bus_word_t                 r_data,
	input  mem_funct_u                funct,
	input  logic [`LSU_LANE_BITS-1:0] lane,
	input  logic                      split,
	output word_t                     load_value
);

	bus_word_t                   first_beat;
	logic [2*`LSU_BUS_WIDTH-1:0] window;
	logic [2*`LSU_BUS_WIDTH-1:0] shifted;
	word_t                       raw;
	logic                        sign_byte;
	logic                        sign_half;

	// low bus word of a split load
	always_ff @(posedge clock) begin
		if (reset) begin
			first_beat <= '0;
		end else if (first_beat_take) begin
			first_beat <= r_data;
		end
	end

	// 16 byte window, the second beat holds the upper bytes
	assign window = split ? {r_data, first_beat} : {{`LSU_BUS_WIDTH{1'b0}}, r_data};

	assign shifted = window >> {lane, 3'b000};
	assign raw = shifted[`LSU_XLEN-1:0];

	assign sign_byte = !funct.ld.is_unsigned && raw[7];
	assign sign_half = !funct.ld.is_unsigned && raw[15];

	always_comb begin
		case (funct.ld.size)
			MEM_BYTE: load_value = {{(`LSU_XLEN-8){sign_byte}}, raw[7:0]};
			MEM_HALF: load_value = {{(`LSU_XLEN-16){sign_half}}, raw[15:0]};
			default:  load_value = raw;
		endcase
	end

endmodule

//--- hdl/store_lane_align.sv
`include "lsu_defs.svh"

module store_lane_align import lsu_pkg::*; (
	input  mem_funct_u                funct,
	input  logic [`LSU_LANE_BITS-1:0] lane,
	input  word_t                     data,
	input  logic                      second_beat,
	output bus_word_t                 w_data,
	output strb_t                     w_strb
);

	logic [`LSU_XLEN/8-1:0]         byte_mask;
	word_t                          masked_data;
	logic [2*`LSU_BUS_WIDTH-1:0]    wide_data;
	logic [2*`LSU_STRB_WIDTH-1:0]   wide_strb;

	// bytes of the register that are stored
	always_comb begin
		case (funct.st.size)
			MEM_BYTE: byte_mask = 'b0001;
			MEM_HALF: byte_mask = 'b0011;
			default:  byte_mask = '1;
		endcase
	end

	always_comb begin
		for (int i = 0; i < `LSU_XLEN/8; i++) begin
			masked_data[8*i +: 8] = byte_mask[i] ? data[8*i +: 8] : 8'h00;
		end
	end

	// shift into a double-width window, upper half is the part past lane 7
	assign wide_data = {{(2*`LSU_BUS_WIDTH-`LSU_XLEN){1'b0}}, masked_data} << {lane, 3'b000};
	assign wide_strb = {{(2*`LSU_STRB_WIDTH-`LSU_XLEN/8){1'b0}}, byte_mask} << lane;

	// wrapped bytes sit in the low lanes, same data serves both beats
	assign w_data = wide_data[2*`LSU_BUS_WIDTH-1:`LSU_BUS_WIDTH] |
		wide_data[`LSU_BUS_WIDTH-1:0];

	// strobe only the lanes that belong to the current beat
	assign w_strb = second_beat ? wide_strb[2*`LSU_STRB_WIDTH-1:`LSU_STRB_WIDTH] :
		wide_strb[`LSU_STRB_WIDTH-1:0];

endmodule

//--- hdl/lsu_stage_reg.sv
`include "lsu_defs.svh"

module lsu_stage_reg import lsu_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       in_valid,
	input  logic       is_store,
	input  mem_funct_u funct,
	input  word_t      base,
	input  word_t      offset,
	input  word_t      store_data,
	input  reg_addr_t  rd,
	input  logic       access_done,
	output logic       allowin,
	output logic       stage_valid,
	output logic       load_go,
	output logic       store_go,
	output logic       split,
	output logic       st_is_store,
	output mem_funct_u st_funct,
	output word_t      eff_addr,
	output word_t      st_data,
	output reg_addr_t  st_rd
);

	word_t                   next_addr;
	mem_size_e               next_size;
	logic [`LSU_LANE_BITS:0] size_span;
	logic [`LSU_LANE_BITS:0] last_lane;
	logic                    next_split;
	logic                    capture;

	// empty, or the current access finishes this cycle
	assign allowin = !stage_valid || access_done;
	assign capture = in_valid && allowin;

	assign next_addr = base + offset;
	// size sits in the low bits of both views
	assign next_size = funct.ld.size;

	// offset of the last byte from the first one
	always_comb begin
		case (next_size)
			MEM_HALF: size_span = 'd1;
			MEM_WORD: size_span = 'd3;
			default:  size_span = 'd0;
		endcase
	end

	// carry out of the lane field means the last byte is in the next bus word
	assign last_lane = {1'b0, next_addr[`LSU_LANE_BITS-1:0]} + size_span;
	assign next_split = last_lane[`LSU_LANE_BITS];

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (allowin) begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (capture) begin
			st_is_store <= is_store;
			st_funct    <= funct;
			eff_addr    <= next_addr;
			st_data     <= store_data;
			st_rd       <= rd;
			split       <= next_split;
		end
	end

	assign load_go  = stage_valid && !st_is_store;
	assign store_go = stage_valid && st_is_store;

endmodule

//--- hdl/lsu_pkg.sv
`include "lsu_defs.svh"

package lsu_pkg;

	typedef logic [`LSU_XLEN-1:0] word_t;
	typedef logic [`LSU_BUS_WIDTH-1:0] bus_word_t;
	typedef logic [`LSU_STRB_WIDTH-1:0] strb_t;
	typedef logic [`LSU_REG_ADDR_WIDTH-1:0] reg_addr_t;

	// low two bits of funct3
	typedef enum logic [1:0] {
		MEM_BYTE = 2'b00,
		MEM_HALF = 2'b01,
		MEM_WORD = 2'b10
	} mem_size_e;

	// funct3 seen as a load or as a store
	typedef union packed {
		struct packed {
			logic      is_unsigned;
			mem_size_e size;
		} ld;
		struct packed {
			logic      reserved;
			mem_size_e size;
		} st;
	} mem_funct_u;

endpackage

//--- hdl/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// register file data and address width
`define LSU_XLEN 32

// data bus word and its byte strobes
`define LSU_BUS_WIDTH 64
`define LSU_STRB_WIDTH 8

`define LSU_REG_ADDR_WIDTH 5

// byte select inside one bus word
`define LSU_LANE_BITS 3

`endif
